// ==== hdl/axil_arb_macros.svh ====
`ifndef AXIL_ARB_MACROS_SVH
`define AXIL_ARB_MACROS_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Arbitration
`define ARB_NUM_MASTERS 3
`define ARB_QUANTUM_CYCLES 16  // Max cycles per grant

`endif

// ==== hdl/axil_pkg.sv ====
`default_nettype none

`include "axil_arb_macros.svh"

package axil_pkg;

    ////////////////////////////////////////////////////////////
    // Channel payloads

    // AW and AR share one layout
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [2:0]              prot;
    } ax_chan_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0]   data;
        logic [`AXIL_DATA_W/8-1:0] strb;  // One bit per byte lane
    } w_chan_t;

endpackage

`default_nettype wire

// ==== hdl/arb_pkg.sv ====
`default_nettype none

`include "axil_arb_macros.svh"

package arb_pkg;

    // One bit per master
    typedef logic [`ARB_NUM_MASTERS-1:0] master_mask_t;

    typedef enum logic [1:0] {
        sched_idle,
        sched_grant,
        sched_switch    // Grant low for one cycle
    } sched_state_t;

endpackage

`default_nettype wire

// ==== hdl/arb_grant_sched.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_arb_macros.svh"

module arb_grant_sched (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire arb_pkg::master_mask_t i_req,
    input  wire logic                  i_done,
    output arb_pkg::master_mask_t      o_grant
);

    localparam int cnt_w = $clog2(`ARB_QUANTUM_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`ARB_QUANTUM_CYCLES - 1);

    arb_pkg::sched_state_t state;
    arb_pkg::master_mask_t snapshot;   // Masters still waiting in this round
    arb_pkg::master_mask_t pick_src;
    arb_pkg::master_mask_t pick;
    logic [cnt_w-1:0]      quantum_cnt;
    logic                  quantum_end;

    ////////////////////////////////////////////////////////////
    // Next master

    // Idle looks at live requests, switch at the stored round
    assign pick_src = (state == arb_pkg::sched_idle) ? i_req : snapshot;

    // Lowest set bit
    assign pick = pick_src & (~pick_src + 1'b1);

    assign quantum_end = (quantum_cnt == cnt_last);

    ////////////////////////////////////////////////////////////
    // Grant sequencing

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state       <= arb_pkg::sched_idle;
            snapshot    <= '0;
            o_grant     <= '0;
            quantum_cnt <= '0;
        end else begin
            case (state)
                arb_pkg::sched_idle, arb_pkg::sched_switch: begin
                    quantum_cnt <= '0;
                    if (|pick_src) begin
                        o_grant  <= pick;
                        snapshot <= pick_src & ~pick;
                        state    <= arb_pkg::sched_grant;
                    end else begin
                        state <= arb_pkg::sched_idle;
                    end
                end

                arb_pkg::sched_grant: begin
                    if (i_done || quantum_end) begin
                        o_grant <= '0;   // Ends on response or budget
                        state   <= arb_pkg::sched_switch;
                    end else begin
                        quantum_cnt <= quantum_cnt + 1'b1;
                    end
                end

                default: begin
                    o_grant <= '0;
                    state   <= arb_pkg::sched_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/arb_req_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_arb_macros.svh"

module arb_req_mux #(
    parameter type payload_t = logic
) (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire arb_pkg::master_mask_t i_grant,
    input  wire arb_pkg::master_mask_t i_valid,
    input  wire payload_t              i_payload [`ARB_NUM_MASTERS],
    input  wire logic                  i_ready,
    output logic                       o_valid,
    output payload_t                   o_payload,
    output arb_pkg::master_mask_t      o_ready
);

    logic sel_valid;
    logic sent;    // One transfer per grant
    logic open;

    always_comb begin
        o_payload = '0;
        sel_valid = 1'b0;
        for (int m = 0; m < `ARB_NUM_MASTERS; m++) begin
            if (i_grant[m]) begin
                o_payload = i_payload[m];
                sel_valid = i_valid[m];
            end
        end
    end

    assign open    = ~sent;
    assign o_valid = sel_valid & open;
    assign o_ready = i_grant & {`ARB_NUM_MASTERS{i_ready & open}};  // Granted master only

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sent <= 1'b0;
        end else if (!(|i_grant)) begin
            sent <= 1'b0;   // Rearm in the switch cycle
        end else if (o_valid && i_ready) begin
            sent <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axil_wr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_arb_macros.svh"

module axil_wr_arbiter (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    // Masters
    input  wire arb_pkg::master_mask_t i_m_aw_valid,
    input  wire axil_pkg::ax_chan_t    i_m_aw [`ARB_NUM_MASTERS],
    output arb_pkg::master_mask_t      o_m_aw_ready,
    input  wire arb_pkg::master_mask_t i_m_w_valid,
    input  wire axil_pkg::w_chan_t     i_m_w [`ARB_NUM_MASTERS],
    output arb_pkg::master_mask_t      o_m_w_ready,
    output arb_pkg::master_mask_t      o_m_b_valid,
    input  wire arb_pkg::master_mask_t i_m_b_ready,
    // Slave
    output logic                       o_s_aw_valid,
    output axil_pkg::ax_chan_t         o_s_aw,
    input  wire logic                  i_s_aw_ready,
    output logic                       o_s_w_valid,
    output axil_pkg::w_chan_t          o_s_w,
    input  wire logic                  i_s_w_ready,
    input  wire logic                  i_s_b_valid,
    output logic                       o_s_b_ready
);

    arb_pkg::master_mask_t grant;
    logic                  b_done;

    arb_grant_sched u_sched (
        .clk     (clk),
        .resetn  (resetn),
        .i_req   (i_m_aw_valid),
        .i_done  (b_done),
        .o_grant (grant)
    );

    arb_req_mux #(.payload_t(axil_pkg::ax_chan_t)) u_aw_mux (
        .clk       (clk),
        .resetn    (resetn),
        .i_grant   (grant),
        .i_valid   (i_m_aw_valid),
        .i_payload (i_m_aw),
        .i_ready   (i_s_aw_ready),
        .o_valid   (o_s_aw_valid),
        .o_payload (o_s_aw),
        .o_ready   (o_m_aw_ready)
    );

    arb_req_mux #(.payload_t(axil_pkg::w_chan_t)) u_w_mux (
        .clk       (clk),
        .resetn    (resetn),
        .i_grant   (grant),
        .i_valid   (i_m_w_valid),
        .i_payload (i_m_w),
        .i_ready   (i_s_w_ready),
        .o_valid   (o_s_w_valid),
        .o_payload (o_s_w),
        .o_ready   (o_m_w_ready)
    );

    // B goes back to the granted master only
    assign o_m_b_valid = grant & {`ARB_NUM_MASTERS{i_s_b_valid}};
    assign o_s_b_ready = |(grant & i_m_b_ready);
    assign b_done      = i_s_b_valid & o_s_b_ready;

endmodule

`default_nettype wire

// ==== hdl/axil_rd_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_arb_macros.svh"

module axil_rd_arbiter (
    input  wire logic                    clk,
    input  wire logic                    resetn,
    // Masters
    input  wire arb_pkg::master_mask_t   i_m_ar_valid,
    input  wire axil_pkg::ax_chan_t      i_m_ar [`ARB_NUM_MASTERS],
    output arb_pkg::master_mask_t        o_m_ar_ready,
    output arb_pkg::master_mask_t        o_m_r_valid,
    input  wire arb_pkg::master_mask_t   i_m_r_ready,
    output logic [`AXIL_DATA_W-1:0]      o_m_r_data [`ARB_NUM_MASTERS],
    // Slave
    output logic                         o_s_ar_valid,
    output axil_pkg::ax_chan_t           o_s_ar,
    input  wire logic                    i_s_ar_ready,
    input  wire logic                    i_s_r_valid,
    output logic                         o_s_r_ready,
    input  wire logic [`AXIL_DATA_W-1:0] i_s_r_data
);

    arb_pkg::master_mask_t grant;
    logic                  r_done;

    arb_grant_sched u_sched (
        .clk     (clk),
        .resetn  (resetn),
        .i_req   (i_m_ar_valid),
        .i_done  (r_done),
        .o_grant (grant)
    );

    arb_req_mux #(.payload_t(axil_pkg::ax_chan_t)) u_ar_mux (
        .clk       (clk),
        .resetn    (resetn),
        .i_grant   (grant),
        .i_valid   (i_m_ar_valid),
        .i_payload (i_m_ar),
        .i_ready   (i_s_ar_ready),
        .o_valid   (o_s_ar_valid),
        .o_payload (o_s_ar),
        .o_ready   (o_m_ar_ready)
    );

    ////////////////////////////////////////////////////////////
    // R routing, other masters see zero data

    always_comb begin
        for (int m = 0; m < `ARB_NUM_MASTERS; m++) begin
            o_m_r_data[m] = grant[m] ? i_s_r_data : '0;
        end
    end

    assign o_m_r_valid = grant & {`ARB_NUM_MASTERS{i_s_r_valid}};
    assign o_s_r_ready = |(grant & i_m_r_ready);
    assign r_done      = i_s_r_valid & o_s_r_ready;  // Read beat accepted

endmodule

`default_nettype wire

// ==== hdl/axil_rr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_arb_macros.svh"

module axil_rr_arbiter (
    input  wire logic                    clk,
    input  wire logic                    resetn,
    // Master write side
    input  wire arb_pkg::master_mask_t   i_m_aw_valid,
    input  wire axil_pkg::ax_chan_t      i_m_aw [`ARB_NUM_MASTERS],
    output arb_pkg::master_mask_t        o_m_aw_ready,
    input  wire arb_pkg::master_mask_t   i_m_w_valid,
    input  wire axil_pkg::w_chan_t       i_m_w [`ARB_NUM_MASTERS],
    output arb_pkg::master_mask_t        o_m_w_ready,
    output arb_pkg::master_mask_t        o_m_b_valid,
    input  wire arb_pkg::master_mask_t   i_m_b_ready,
    // Master read side
    input  wire arb_pkg::master_mask_t   i_m_ar_valid,
    input  wire axil_pkg::ax_chan_t      i_m_ar [`ARB_NUM_MASTERS],
    output arb_pkg::master_mask_t        o_m_ar_ready,
    output arb_pkg::master_mask_t        o_m_r_valid,
    input  wire arb_pkg::master_mask_t   i_m_r_ready,
    output logic [`AXIL_DATA_W-1:0]      o_m_r_data [`ARB_NUM_MASTERS],
    // Slave write side
    output logic                         o_s_aw_valid,
    output axil_pkg::ax_chan_t           o_s_aw,
    input  wire logic                    i_s_aw_ready,
    output logic                         o_s_w_valid,
    output axil_pkg::w_chan_t            o_s_w,
    input  wire logic                    i_s_w_ready,
    input  wire logic                    i_s_b_valid,
    output logic                         o_s_b_ready,
    // Slave read side
    output logic                         o_s_ar_valid,
    output axil_pkg::ax_chan_t           o_s_ar,
    input  wire logic                    i_s_ar_ready,
    input  wire logic                    i_s_r_valid,
    output logic                         o_s_r_ready,
    input  wire logic [`AXIL_DATA_W-1:0] i_s_r_data
);

    // Write and read paths never interact
    axil_wr_arbiter u_wr (
        .clk          (clk),
        .resetn       (resetn),
        .i_m_aw_valid (i_m_aw_valid),
        .i_m_aw       (i_m_aw),
        .o_m_aw_ready (o_m_aw_ready),
        .i_m_w_valid  (i_m_w_valid),
        .i_m_w        (i_m_w),
        .o_m_w_ready  (o_m_w_ready),
        .o_m_b_valid  (o_m_b_valid),
        .i_m_b_ready  (i_m_b_ready),
        .o_s_aw_valid (o_s_aw_valid),
        .o_s_aw       (o_s_aw),
        .i_s_aw_ready (i_s_aw_ready),
        .o_s_w_valid  (o_s_w_valid),
        .o_s_w        (o_s_w),
        .i_s_w_ready  (i_s_w_ready),
        .i_s_b_valid  (i_s_b_valid),
        .o_s_b_ready  (o_s_b_ready)
    );

    axil_rd_arbiter u_rd (
        .clk          (clk),
        .resetn       (resetn),
        .i_m_ar_valid (i_m_ar_valid),
        .i_m_ar       (i_m_ar),
        .o_m_ar_ready (o_m_ar_ready),
        .o_m_r_valid  (o_m_r_valid),
        .i_m_r_ready  (i_m_r_ready),
        .o_m_r_data   (o_m_r_data),
        .o_s_ar_valid (o_s_ar_valid),
        .o_s_ar       (o_s_ar),
        .i_s_ar_ready (i_s_ar_ready),
        .i_s_r_valid  (i_s_r_valid),
        .o_s_r_ready  (o_s_r_ready),
        .i_s_r_data   (i_s_r_data)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 4
) (
    output logic o_clk,
    output logic o_resetn
);

    initial begin
        o_clk = 1'b0;
        forever #(period_ns / 2) o_clk = ~o_clk;
    end

    initial begin
        o_resetn = 1'b1;
        #1 o_resetn = 1'b0;   // Falling edge seen by every flop
        repeat (reset_cycles) @(posedge o_clk);
        @(negedge o_clk);
        o_resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/axil_rr_arbiter_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_rr_arbiter_assert (
    input wire logic                  clk,
    input wire logic                  resetn,
    input wire arb_pkg::master_mask_t i_aw_ready,
    input wire arb_pkg::master_mask_t i_w_ready,
    input wire arb_pkg::master_mask_t i_ar_ready,
    input wire arb_pkg::master_mask_t i_b_valid,
    input wire arb_pkg::master_mask_t i_r_valid,
    input wire logic                  i_s_aw_valid,
    input wire logic                  i_s_w_valid,
    input wire logic                  i_s_ar_valid
);

    int failures = 0;

    ////////////////////////////////////////////////////////////
    // One master at a time

    ready_one_master: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(i_aw_ready) && $onehot0(i_w_ready) && $onehot0(i_ar_ready))
        else begin
            $error("A request ready reached more than one master");
            failures++;
        end

    resp_one_master: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(i_b_valid) && $onehot0(i_r_valid))
        else begin
            $error("A response valid reached more than one master");
            failures++;
        end

    ////////////////////////////////////////////////////////////
    // Quiet bus during reset

    quiet_in_reset: assert property (@(posedge clk)
        !resetn |-> !(i_s_aw_valid || i_s_w_valid || i_s_ar_valid
                      || (|i_aw_ready) || (|i_w_ready) || (|i_ar_ready)))
        else begin
            $error("Slave valid or master ready high while reset is held");
            failures++;
        end

endmodule

bind axil_rr_arbiter axil_rr_arbiter_assert u_axil_rr_arbiter_assert (
    .clk          (clk),
    .resetn       (resetn),
    .i_aw_ready   (o_m_aw_ready),
    .i_w_ready    (o_m_w_ready),
    .i_ar_ready   (o_m_ar_ready),
    .i_b_valid    (o_m_b_valid),
    .i_r_valid    (o_m_r_valid),
    .i_s_aw_valid (o_s_aw_valid),
    .i_s_w_valid  (o_s_w_valid),
    .i_s_ar_valid (o_s_ar_valid)
);

`default_nettype wire

// ==== verif/tb_axil_rr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_arb_macros.svh"

module tb_axil_rr_arbiter;

    localparam int n_m        = `ARB_NUM_MASTERS;
    localparam int max_cycles = 2000;   // 5 tests x 3 masters x 2 quanta, wide margin
    localparam int long_delay = `ARB_QUANTUM_CYCLES + 8;

    logic clk;
    logic resetn;

    // DUT ports, same names as on the DUT
    arb_pkg::master_mask_t   i_m_aw_valid = '0;
    arb_pkg::master_mask_t   i_m_w_valid = '0;
    arb_pkg::master_mask_t   i_m_ar_valid = '0;
    arb_pkg::master_mask_t   i_m_b_ready = '1;
    arb_pkg::master_mask_t   i_m_r_ready = '1;
    arb_pkg::master_mask_t   o_m_aw_ready;
    arb_pkg::master_mask_t   o_m_w_ready;
    arb_pkg::master_mask_t   o_m_ar_ready;
    arb_pkg::master_mask_t   o_m_b_valid;
    arb_pkg::master_mask_t   o_m_r_valid;
    axil_pkg::ax_chan_t      i_m_aw [n_m];
    axil_pkg::ax_chan_t      i_m_ar [n_m];
    axil_pkg::w_chan_t       i_m_w [n_m];
    logic [`AXIL_DATA_W-1:0] o_m_r_data [n_m];
    logic                    i_s_aw_ready = 1'b1;
    logic                    i_s_w_ready = 1'b1;
    logic                    i_s_ar_ready = 1'b1;
    logic                    i_s_b_valid = 1'b0;
    logic                    i_s_r_valid = 1'b0;
    logic [`AXIL_DATA_W-1:0] i_s_r_data = '0;
    logic                    o_s_aw_valid;
    logic                    o_s_w_valid;
    logic                    o_s_ar_valid;
    logic                    o_s_b_ready;
    logic                    o_s_r_ready;
    axil_pkg::ax_chan_t      o_s_aw;
    axil_pkg::ax_chan_t      o_s_ar;
    axil_pkg::w_chan_t       o_s_w;

    // Slave model and scoreboard
    int                      seed = 32'h42d;
    int                      cycle = 0;
    int                      errors = 0;
    int                      checks = 0;
    int                      aw_cycle = 0;
    int                      b_wait = 0;
    int                      r_wait = 0;
    logic                    wr_pend = 1'b0;
    logic                    rd_pend = 1'b0;
    logic                    long_b = 1'b0;
    logic [`AXIL_ADDR_W-1:0] r_addr = '0;
    logic [`AXIL_ADDR_W-1:0] rd_addr [n_m];
    arb_pkg::master_mask_t   aw_acc = '0;
    arb_pkg::master_mask_t   w_acc = '0;
    arb_pkg::master_mask_t   ar_acc = '0;
    int                      b_cnt [n_m];
    int                      b_vld [n_m];
    int                      r_cnt [n_m];
    axil_pkg::ax_chan_t      aw_log [$];
    axil_pkg::ax_chan_t      ar_log [$];
    axil_pkg::w_chan_t       w_log [$];
    int                      r_order [$];

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_resetn(resetn));

    axil_rr_arbiter u_axil_rr_arbiter (.*);

    ////////////////////////////////////////////////////////////
    // Expected values

    function automatic axil_pkg::ax_chan_t aw_for(input int m);
        axil_pkg::ax_chan_t aw;
        aw.addr = 32'h4000_1000 + m * 36;
        aw.prot = 3'(m + 1);
        return aw;
    endfunction

    function automatic axil_pkg::ax_chan_t ar_for(input int m);
        axil_pkg::ax_chan_t ar;
        ar.addr = 32'h2000_0800 + m * 68;
        ar.prot = 3'(m);
        return ar;
    endfunction

    function automatic axil_pkg::w_chan_t w_for(input int m);
        axil_pkg::w_chan_t w;
        w.data = 32'hc0de_0000 + m * 32'h111;
        w.strb = 4'hf >> m;
        return w;
    endfunction

    // Slave read content over the whole address
    function automatic logic [`AXIL_DATA_W-1:0] read_word(input logic [`AXIL_ADDR_W-1:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int short_delay();
        return 1 + ($unsigned($random(seed)) % 8);   // Well inside one quantum
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic start_write(input int m);
        i_m_aw[m]       = aw_for(m);
        i_m_w[m]        = w_for(m);
        i_m_aw_valid[m] = 1'b1;
        i_m_w_valid[m]  = 1'b1;
    endtask

    task automatic start_read(input int m);
        i_m_ar[m]       = ar_for(m);
        rd_addr[m]      = i_m_ar[m].addr;
        i_m_ar_valid[m] = 1'b1;
    endtask

    task automatic clear_logs();
        aw_log.delete();
        ar_log.delete();
        w_log.delete();
        r_order.delete();
        for (int m = 0; m < n_m; m++) begin
            b_cnt[m] = 0;
            b_vld[m] = 0;
            r_cnt[m] = 0;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("Test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors found");
    endtask

    ////////////////////////////////////////////////////////////
    // Handshakes seen at the rising edge

    always @(posedge clk) begin
        cycle++;
        if (o_s_aw_valid && i_s_aw_ready) begin
            aw_log.push_back(o_s_aw);
            aw_cycle = cycle;
            wr_pend  = 1'b1;   // A new write drops an unanswered one
            b_wait   = long_b ? long_delay : short_delay();
            long_b   = 1'b0;
        end
        if (o_s_w_valid && i_s_w_ready) w_log.push_back(o_s_w);
        if (i_s_b_valid && o_s_b_ready) wr_pend = 1'b0;
        if (o_s_ar_valid && i_s_ar_ready) begin
            ar_log.push_back(o_s_ar);
            r_addr  = o_s_ar.addr;
            rd_pend = 1'b1;
            r_wait  = short_delay();
        end
        if (i_s_r_valid && o_s_r_ready) rd_pend = 1'b0;
        aw_acc |= i_m_aw_valid & o_m_aw_ready;
        w_acc  |= i_m_w_valid & o_m_w_ready;
        ar_acc |= i_m_ar_valid & o_m_ar_ready;
        for (int m = 0; m < n_m; m++) begin
            if (o_m_b_valid[m]) b_vld[m]++;
            if (o_m_b_valid[m] && i_m_b_ready[m]) b_cnt[m]++;
            if (o_m_r_valid[m] && i_m_r_ready[m]) begin
                r_cnt[m]++;
                r_order.push_back(m);
                check_eq(o_m_r_data[m], read_word(rd_addr[m]), "read data at requester");
                for (int k = 0; k < n_m; k++) begin
                    if (k != m) check_eq(o_m_r_data[k], '0, "read data at other master");
                end
            end
        end
    end

    // Slave responses and master valid drops
    always @(negedge clk) begin
        if (wr_pend && b_wait > 0) b_wait--;
        if (rd_pend && r_wait > 0) r_wait--;
        i_s_b_valid  = wr_pend && (b_wait == 0);
        i_s_r_valid  = rd_pend && (r_wait == 0);
        i_s_r_data   = i_s_r_valid ? read_word(r_addr) : '0;
        i_m_aw_valid = i_m_aw_valid & ~aw_acc;
        i_m_w_valid  = i_m_w_valid & ~w_acc;
        i_m_ar_valid = i_m_ar_valid & ~ar_acc;
        aw_acc = '0;
        w_acc  = '0;
        ar_acc = '0;
    end

    initial begin : watchdog
        while (cycle < max_cycles) @(negedge clk);
        $display("Timeout: tests still running after %0d cycles", max_cycles);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Tests

    initial begin
        int err_before;
        int start;

        for (int m = 0; m < n_m; m++) begin
            i_m_aw[m]  = '0;
            i_m_w[m]   = '0;
            i_m_ar[m]  = '0;
            rd_addr[m] = '0;
        end
        clear_logs();

        // Requests while reset is held must not get through
        wait (resetn === 1'b0);
        @(negedge clk);
        i_m_aw_valid = '1;
        i_m_w_valid  = '1;
        i_m_ar_valid = '1;
        @(negedge clk);
        i_m_aw_valid = '0;
        i_m_w_valid  = '0;
        i_m_ar_valid = '0;
        wait (resetn === 1'b1);
        @(negedge clk);

        err_before = errors;
        check_eq({o_s_aw_valid, o_s_w_valid, o_s_ar_valid}, '0, "slave valids after reset");
        check_eq({o_m_aw_ready, o_m_w_ready, o_m_ar_ready}, '0, "master readys after reset");
        check_eq({o_m_b_valid, o_m_r_valid}, '0, "master response valids after reset");
        report_test(1, "reset state", err_before);

        err_before = errors;
        start_write(1);
        start = cycle;
        while (b_cnt[1] < 1) @(negedge clk);
        check_eq(aw_log.size(), 1, "AW transfers at slave");
        check_eq(aw_log[0], aw_for(1), "AW address and prot at slave");
        check_eq(w_log[0], w_for(1), "W data and strobe at slave");
        check_eq(aw_cycle - start, 2, "edges from AW valid to slave handshake");
        check_eq(b_cnt[1], 1, "B responses at master 1");
        check_eq(b_vld[0] + b_vld[2], 0, "B valid cycles at masters 0 and 2");
        report_test(2, "single write", err_before);

        repeat (4) @(negedge clk);
        clear_logs();
        err_before = errors;
        for (int m = 0; m < n_m; m++) start_write(m);
        for (int m = 0; m < n_m; m++) begin
            while (b_cnt[m] < 1) @(negedge clk);
        end
        for (int m = 0; m < n_m; m++) begin
            check_eq(aw_log[m], aw_for(m), $sformatf("AW order, slot %0d", m));
            check_eq(w_log[m], w_for(m), $sformatf("W order, slot %0d", m));
            check_eq(b_cnt[m], 1, $sformatf("B responses at master %0d", m));
        end
        report_test(3, "concurrent writes", err_before);

        repeat (4) @(negedge clk);
        clear_logs();
        err_before = errors;
        start_read(0);
        start_read(2);
        start_write(1);
        while (r_cnt[0] < 1 || r_cnt[2] < 1 || b_cnt[1] < 1) @(negedge clk);
        check_eq(r_order.size(), 2, "R transfers at masters");
        check_eq(r_order[0], 0, "first read served");
        check_eq(r_order[1], 2, "second read served");
        check_eq(ar_log[0], ar_for(0), "AR address and prot of first read");
        check_eq(ar_log[1], ar_for(2), "AR address and prot of second read");
        check_eq(r_cnt[1], 0, "R transfers at master 1");
        check_eq(aw_log[0], aw_for(1), "AW beside reads");
        check_eq(b_cnt[1], 1, "B responses at master 1");
        report_test(4, "reads beside a write", err_before);

        repeat (4) @(negedge clk);
        clear_logs();
        err_before = errors;
        long_b = 1'b1;   // First write answered after the quantum
        start_write(0);
        start_write(1);
        while (b_cnt[1] < 1) @(negedge clk);
        check_eq(aw_log.size(), 2, "AW transfers at slave");
        check_eq(aw_log[1], aw_for(1), "AW after timeout");
        check_eq(b_vld[0], 0, "B valid cycles at abandoned master");
        check_eq(b_cnt[1], 1, "B responses at master 1");
        report_test(5, "quantum timeout", err_before);

        repeat (4) @(negedge clk);
        errors += u_axil_rr_arbiter.u_axil_rr_arbiter_assert.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/axil_pkg.sv
hdl/arb_pkg.sv
hdl/arb_grant_sched.sv
hdl/arb_req_mux.sv
hdl/axil_wr_arbiter.sv
hdl/axil_rd_arbiter.sv
hdl/axil_rr_arbiter.sv
verif/tb_clk_gen.sv
verif/axil_rr_arbiter_assert.sv
verif/tb_axil_rr_arbiter.sv

// ==== Bender.yml ====
package:
  name: axil_rr_arbiter

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axil_pkg.sv
      - hdl/arb_pkg.sv
      - hdl/arb_grant_sched.sv
      - hdl/arb_req_mux.sv
      - hdl/axil_wr_arbiter.sv
      - hdl/axil_rd_arbiter.sv
      - hdl/axil_rr_arbiter.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_clk_gen.sv
      - verif/axil_rr_arbiter_assert.sv
      - verif/tb_axil_rr_arbiter.sv
